// File: ahbl_xbar_sys.f
source/ahbl_pkg.sv
source/ahbl_splitter.sv
source/ahbl_arbiter.sv
source/ahbl_crossbar.sv
source/ahbl_sram_slave.sv
source/ahbl_xbar_sys.sv
test/tb_ahbl_xbar_sys.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the AHB-Lite crossbar testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_ahbl_xbar_sys \
	-f ahbl_xbar_sys.f -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit $status
fi

./obj_dir/Vtb_ahbl_xbar_sys
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation run exited with status $status"
	exit $status
fi
exit 0

// File: source/ahbl_arbiter.sv
// ========================================
// AHB-Lite arbiter
// Shares one slave lane between all
// masters with fixed priority, lowest
// index first. A master that loses has its
// address phase held and is stalled until
// the held transfer has been replayed
// ========================================

`timescale 1ns/10ps

module ahbl_arbiter (
	input  logic                              clk,
	input  logic                              rst_n,

	// Master side, one entry per master
	input  ahbl_pkg::ahbl_req_t               src_req    [ahbl_pkg::N_MASTERS],
	input  logic [ahbl_pkg::N_MASTERS-1:0]    src_hready,
	input  logic [ahbl_pkg::W_DATA-1:0]       src_wdata  [ahbl_pkg::N_MASTERS],
	output ahbl_pkg::ahbl_resp_t              src_resp   [ahbl_pkg::N_MASTERS],

	// Slave lane
	output ahbl_pkg::ahbl_req_t               dst_req,
	output logic                              dst_hready,
	output logic [ahbl_pkg::W_DATA-1:0]       dst_wdata,
	input  ahbl_pkg::ahbl_resp_t              dst_resp
);

	import ahbl_pkg::*;

	// Live address phases accepted by their master this cycle
	logic [N_MASTERS-1:0] live;
	logic [N_MASTERS-1:0] cand;
	logic [N_MASTERS-1:0] grant;

	// Held address phases of stalled masters
	logic [N_MASTERS-1:0] hold_vld;
	ahbl_req_t            hold_req [N_MASTERS];

	// One-hot owner of the slave data phase
	logic [N_MASTERS-1:0] dp_own;

	// Single slave on the lane, so its ready is the lane ready
	assign dst_hready = dst_resp.hready_resp;

	// ========================================
	// Request selection
	// ========================================

	always_comb begin
		for (int i = 0; i < N_MASTERS; i++) begin
			live[i] = ahbl_active(src_req[i].htrans) && src_hready[i];
			cand[i] = live[i] || hold_vld[i];
		end
	end

	// Fixed priority, the last match in a downward scan wins
	always_comb begin
		grant = '0;
		for (int i = N_MASTERS - 1; i >= 0; i--) begin
			if (cand[i]) begin
				grant    = '0;
				grant[i] = 1'b1;
			end
		end
	end

	always_comb begin
		dst_req        = '0;
		dst_req.htrans = HTRANS_IDLE;
		for (int i = 0; i < N_MASTERS; i++) begin
			if (grant[i]) begin
				dst_req = hold_vld[i] ? hold_req[i] : src_req[i];
			end
		end
	end

	// ========================================
	// Hold and ownership state
	// ========================================

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			hold_vld <= '0;
			dp_own   <= '0;
		end else begin
			if (dst_hready) begin
				dp_own <= grant;
			end
			for (int i = 0; i < N_MASTERS; i++) begin
				if (dst_hready && grant[i]) begin
					hold_vld[i] <= 1'b0;
				end else if (live[i]) begin
					hold_vld[i] <= 1'b1;
				end
			end
		end
	end

	// Payload of a request that could not go out this cycle
	always_ff @(posedge clk) begin
		for (int i = 0; i < N_MASTERS; i++) begin
			if (live[i] && !(dst_hready && grant[i])) begin
				hold_req[i] <= src_req[i];
			end
		end
	end

	// ========================================
	// Data phase routing
	// ========================================

	always_comb begin
		dst_wdata = '0;
		for (int i = 0; i < N_MASTERS; i++) begin
			if (dp_own[i]) begin
				dst_wdata = src_wdata[i];
			end
		end
	end

	// Owner sees the slave, a waiting master is stalled, others idle high
	always_comb begin
		for (int i = 0; i < N_MASTERS; i++) begin
			src_resp[i].hready_resp = !hold_vld[i];
			src_resp[i].hresp       = HRESP_OKAY;
			src_resp[i].hrdata      = dst_resp.hrdata;
			if (dp_own[i]) begin
				src_resp[i] = dst_resp;
			end
		end
	end

endmodule

// File: source/ahbl_crossbar.sv
// ========================================
// AHB-Lite crossbar
// Grid of one splitter per master and one
// arbiter per slave, with the crosspoints
// carried as struct arrays
// ========================================

`timescale 1ns/10ps

module ahbl_crossbar (
	input  logic                              clk,
	input  logic                              rst_n,

	// Master ports
	input  ahbl_pkg::ahbl_req_t               mst_req    [ahbl_pkg::N_MASTERS],
	input  logic [ahbl_pkg::W_DATA-1:0]       mst_wdata  [ahbl_pkg::N_MASTERS],
	output ahbl_pkg::ahbl_resp_t              mst_resp   [ahbl_pkg::N_MASTERS],

	// Slave ports
	output ahbl_pkg::ahbl_req_t               slv_req    [ahbl_pkg::N_SLAVES],
	output logic [ahbl_pkg::N_SLAVES-1:0]     slv_hready,
	output logic [ahbl_pkg::W_DATA-1:0]       slv_wdata  [ahbl_pkg::N_SLAVES],
	input  ahbl_pkg::ahbl_resp_t              slv_resp   [ahbl_pkg::N_SLAVES]
);

	import ahbl_pkg::*;

	// ========================================
	// Crosspoints, indexed [master][slave]
	// ========================================

	ahbl_req_t           req_xbar    [N_MASTERS][N_SLAVES];
	logic [N_SLAVES-1:0] hready_xbar [N_MASTERS];
	logic [W_DATA-1:0]   wdata_xbar  [N_MASTERS][N_SLAVES];
	ahbl_resp_t          resp_xbar   [N_MASTERS][N_SLAVES];

	genvar i, j;

	// Masters see their own response ready as hready
	for (i = 0; i < N_MASTERS; i++) begin : g_split
		ahbl_splitter u_splitter (
			.clk        (clk),
			.rst_n      (rst_n),
			.src_req    (mst_req[i]),
			.src_hready (mst_resp[i].hready_resp),
			.src_wdata  (mst_wdata[i]),
			.src_resp   (mst_resp[i]),
			.dst_req    (req_xbar[i]),
			.dst_hready (hready_xbar[i]),
			.dst_wdata  (wdata_xbar[i]),
			.dst_resp   (resp_xbar[i])
		);
	end

	for (j = 0; j < N_SLAVES; j++) begin : g_arb
		ahbl_req_t            arb_req   [N_MASTERS];
		logic [N_MASTERS-1:0] arb_hready;
		logic [W_DATA-1:0]    arb_wdata [N_MASTERS];
		ahbl_resp_t           arb_resp  [N_MASTERS];

		// Column j of the grid
		for (i = 0; i < N_MASTERS; i++) begin : g_col
			assign arb_req[i]      = req_xbar[i][j];
			assign arb_hready[i]   = hready_xbar[i][j];
			assign arb_wdata[i]    = wdata_xbar[i][j];
			assign resp_xbar[i][j] = arb_resp[i];
		end

		ahbl_arbiter u_arbiter (
			.clk        (clk),
			.rst_n      (rst_n),
			.src_req    (arb_req),
			.src_hready (arb_hready),
			.src_wdata  (arb_wdata),
			.src_resp   (arb_resp),
			.dst_req    (slv_req[j]),
			.dst_hready (slv_hready[j]),
			.dst_wdata  (slv_wdata[j]),
			.dst_resp   (slv_resp[j])
		);
	end

endmodule

// File: source/ahbl_pkg.sv
// ========================================
// AHB-Lite crossbar shared definitions
// Bus widths, transfer and response codes,
// slave address map and the packed request
// and response payloads of every port
// ========================================

package ahbl_pkg;

	// Crossbar size and bus widths
	localparam int N_MASTERS = 2;
	localparam int N_SLAVES  = 2;
	localparam int W_ADDR    = 32;
	localparam int W_DATA    = 32;

	// Slave regions, index j holds slave j
	localparam logic [N_SLAVES-1:0][W_ADDR-1:0] ADDR_MAP  = {32'h2000_0000, 32'h0000_0000};
	localparam logic [N_SLAVES-1:0][W_ADDR-1:0] ADDR_MASK = {32'hf000_0000, 32'hf000_0000};

	// Local memory depth in words
	localparam int SRAM_WORDS = 256;
	localparam int W_SRAM_IDX = $clog2(SRAM_WORDS);

	// HTRANS encodings
	localparam logic [1:0] HTRANS_IDLE   = 2'b00;
	localparam logic [1:0] HTRANS_BUSY   = 2'b01;
	localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
	localparam logic [1:0] HTRANS_SEQ    = 2'b11;

	// HRESP encodings
	localparam logic HRESP_OKAY  = 1'b0;
	localparam logic HRESP_ERROR = 1'b1;

	// Address phase, driven by a master
	typedef struct packed {
		logic [W_ADDR-1:0] haddr;
		logic              hwrite;
		logic [1:0]        htrans;
		logic [2:0]        hsize;
		logic [2:0]        hburst;
		logic [3:0]        hprot;
		logic              hmastlock;
	} ahbl_req_t;

	// Data phase return, driven by a slave
	typedef struct packed {
		logic              hready_resp;
		logic              hresp;
		logic [W_DATA-1:0] hrdata;
	} ahbl_resp_t;

	// NONSEQ and SEQ carry a transfer, IDLE and BUSY do not
	function automatic logic ahbl_active(input logic [1:0] htrans);
		return (htrans == HTRANS_NONSEQ) || (htrans == HTRANS_SEQ);
	endfunction

endpackage

// File: source/ahbl_splitter.sv
// ========================================
// AHB-Lite splitter
// One master port fanned out to N slave
// lanes by address decode. The data-phase
// response is steered back from the lane
// chosen in the address phase. Unmapped
// addresses get a two-cycle ERROR
// ========================================

`timescale 1ns/10ps

module ahbl_splitter (
	input  logic                              clk,
	input  logic                              rst_n,

	// Master side
	input  ahbl_pkg::ahbl_req_t               src_req,
	input  logic                              src_hready,
	input  logic [ahbl_pkg::W_DATA-1:0]       src_wdata,
	output ahbl_pkg::ahbl_resp_t              src_resp,

	// Slave lanes
	output ahbl_pkg::ahbl_req_t               dst_req    [ahbl_pkg::N_SLAVES],
	output logic [ahbl_pkg::N_SLAVES-1:0]     dst_hready,
	output logic [ahbl_pkg::W_DATA-1:0]       dst_wdata  [ahbl_pkg::N_SLAVES],
	input  ahbl_pkg::ahbl_resp_t              dst_resp   [ahbl_pkg::N_SLAVES]
);

	import ahbl_pkg::*;

	logic                active;
	logic [N_SLAVES-1:0] hit;

	// Data-phase state
	logic [N_SLAVES-1:0] dsel;
	logic                err_first;
	logic                err_second;

	// ========================================
	// Address phase decode
	// ========================================

	assign active = ahbl_active(src_req.htrans);

	always_comb begin
		for (int j = 0; j < N_SLAVES; j++) begin
			hit[j] = (src_req.haddr & ADDR_MASK[j]) == ADDR_MAP[j];
		end
	end

	// Unselected lanes see IDLE, everything else passes straight on
	always_comb begin
		for (int j = 0; j < N_SLAVES; j++) begin
			dst_req[j] = src_req;
			if (!hit[j]) begin
				dst_req[j].htrans = HTRANS_IDLE;
			end
			dst_wdata[j] = src_wdata;
		end
	end

	assign dst_hready = {N_SLAVES{src_hready}};

	// ========================================
	// Data phase tracking
	// ========================================

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			dsel       <= '0;
			err_first  <= 1'b0;
			err_second <= 1'b0;
		end else if (src_hready) begin
			dsel       <= active ? hit : '0;
			err_first  <= active && (hit == '0);
			err_second <= 1'b0;
		end else if (err_first) begin
			// First ERROR cycle holds the master, second one releases it
			err_first  <= 1'b0;
			err_second <= 1'b1;
		end
	end

	// ========================================
	// Response steering
	// ========================================

	always_comb begin
		src_resp.hready_resp = 1'b1;
		src_resp.hresp       = HRESP_OKAY;
		src_resp.hrdata      = '0;
		if (err_first) begin
			src_resp.hready_resp = 1'b0;
			src_resp.hresp       = HRESP_ERROR;
		end else if (err_second) begin
			src_resp.hresp = HRESP_ERROR;
		end else begin
			for (int j = 0; j < N_SLAVES; j++) begin
				if (dsel[j]) begin
					src_resp = dst_resp[j];
				end
			end
		end
	end

endmodule

// File: source/ahbl_sram_slave.sv
// ========================================
// AHB-Lite SRAM slave
// Word-wide local memory. Each transfer
// takes WAIT_STATES cycles with ready low
// before its data phase completes
// ========================================

`timescale 1ns/10ps

module ahbl_sram_slave #(
	parameter int WAIT_STATES = 0
) (
	input  logic                              clk,
	input  logic                              rst_n,
	input  ahbl_pkg::ahbl_req_t               req,
	input  logic                              hready,
	input  logic [ahbl_pkg::W_DATA-1:0]       wdata,
	output ahbl_pkg::ahbl_resp_t              resp
);

	import ahbl_pkg::*;

	localparam int W_CNT = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

	logic [W_DATA-1:0]     mem [SRAM_WORDS];

	// Registered address phase
	logic                  dp_vld;
	logic                  dp_write;
	logic [W_SRAM_IDX-1:0] dp_addr;
	logic [W_CNT-1:0]      wait_cnt;
	logic                  dp_done;

	assign dp_done = dp_vld && (wait_cnt == '0);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			dp_vld   <= 1'b0;
			wait_cnt <= '0;
		end else if (hready) begin
			dp_vld   <= ahbl_active(req.htrans);
			wait_cnt <= W_CNT'(WAIT_STATES);
		end else if (wait_cnt != '0) begin
			wait_cnt <= wait_cnt - 1'b1;
		end
	end

	// Word index only, upper region bits alias
	always_ff @(posedge clk) begin
		if (hready) begin
			dp_write <= req.hwrite;
			dp_addr  <= req.haddr[2 +: W_SRAM_IDX];
		end
	end

	always_ff @(posedge clk) begin
		if (dp_done && dp_write) begin
			mem[dp_addr] <= wdata;
		end
	end

	assign resp.hready_resp = !dp_vld || dp_done;
	assign resp.hresp       = HRESP_OKAY;
	assign resp.hrdata      = mem[dp_addr];

endmodule

// File: source/ahbl_xbar_sys.sv
// ========================================
// AHB-Lite crossbar system
// Two-master crossbar in front of two
// local SRAM slaves, the second one with
// a wait state on every transfer
// ========================================

`timescale 1ns/10ps

module ahbl_xbar_sys (
	input  logic                              clk,
	input  logic                              rst_n,
	input  ahbl_pkg::ahbl_req_t               mst_req    [ahbl_pkg::N_MASTERS],
	input  logic [ahbl_pkg::W_DATA-1:0]       mst_wdata  [ahbl_pkg::N_MASTERS],
	output ahbl_pkg::ahbl_resp_t              mst_resp   [ahbl_pkg::N_MASTERS]
);

	import ahbl_pkg::*;

	// Slave lanes between crossbar and memories
	ahbl_req_t           slv_req    [N_SLAVES];
	logic [N_SLAVES-1:0] slv_hready;
	logic [W_DATA-1:0]   slv_wdata  [N_SLAVES];
	ahbl_resp_t          slv_resp   [N_SLAVES];

	ahbl_crossbar u_ahbl_crossbar (
		.clk        (clk),
		.rst_n      (rst_n),
		.mst_req    (mst_req),
		.mst_wdata  (mst_wdata),
		.mst_resp   (mst_resp),
		.slv_req    (slv_req),
		.slv_hready (slv_hready),
		.slv_wdata  (slv_wdata),
		.slv_resp   (slv_resp)
	);

	// Slave j gets j wait states
	for (genvar j = 0; j < N_SLAVES; j++) begin : g_sram
		ahbl_sram_slave #(
			.WAIT_STATES (j)
		) u_sram (
			.clk    (clk),
			.rst_n  (rst_n),
			.req    (slv_req[j]),
			.hready (slv_hready[j]),
			.wdata  (slv_wdata[j]),
			.resp   (slv_resp[j])
		);
	end

endmodule

// File: test/ahbl_testdata.txt
# Columns are master, rw, address, data and expected hresp
# For rw 1 data is written and for rw 0 it is the expected read data
# Both masters on slave 0 at disjoint addresses
0 1 00000000 a5a50000 0
1 1 00000080 5a5a0080 0
0 1 00000004 a5a50004 0
1 1 00000084 5a5a0084 0
0 0 00000000 a5a50000 0
1 0 00000080 5a5a0080 0
0 0 00000004 a5a50004 0
1 0 00000084 5a5a0084 0
# Slave 1 with its wait state, while the other master uses slave 0
0 1 20000100 c3c30100 0
1 1 00000088 5a5a0088 0
0 1 20000104 c3c30104 0
0 0 20000100 c3c30100 0
1 0 00000088 5a5a0088 0
0 0 20000104 c3c30104 0
0 1 00000008 a5a50008 0
1 1 20000180 3c3c0180 0
0 0 00000008 a5a50008 0
1 0 20000180 3c3c0180 0
# Unmapped region, then a valid transfer
0 0 40000000 00000000 1
0 1 0000000c 0badf00d 0
0 0 0000000c 0badf00d 0
1 1 40000010 00000000 1
1 0 20000180 3c3c0180 0

// File: test/tb_ahbl_xbar_sys.sv
// ========================================
// AHB-Lite crossbar system testbench
// Two masters replay a transfer list in
// parallel and check hresp and read data
// ========================================

`timescale 1ns/10ps

module tb_ahbl_xbar_sys;

	import ahbl_pkg::*;

	// One line of the transfer list
	typedef struct packed {
		int                master;
		logic              write;
		logic [W_ADDR-1:0] addr;
		logic [W_DATA-1:0] data;
		logic              resp;
	} xfer_t;

	logic              clk;
	logic              rst_n;
	ahbl_req_t         mst_req   [N_MASTERS];
	logic [W_DATA-1:0] mst_wdata [N_MASTERS];
	ahbl_resp_t        mst_resp  [N_MASTERS];
	xfer_t             xfers     [$];

	ahbl_xbar_sys u_ahbl_xbar_sys (
		.clk       (clk),
		.rst_n     (rst_n),
		.mst_req   (mst_req),
		.mst_wdata (mst_wdata),
		.mst_resp  (mst_resp)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic report_mismatch(input string sig, input int m,
			input logic [31:0] got, input logic [31:0] exp);
		abort_run($sformatf("[ERROR] %0t mst_resp[%0d].%s got %h expected %h",
			$time, m, sig, got, exp));
	endtask

	task automatic load_transfers();
		int                fd;
		int                n;
		int                f_m;
		int                f_rw;
		int                f_resp;
		logic [W_ADDR-1:0] f_addr;
		logic [W_DATA-1:0] f_data;
		string             line;
		fd = $fopen("test/ahbl_testdata.txt", "r");
		if (fd == 0) begin
			abort_run("cannot open the transfer list test/ahbl_testdata.txt");
		end else begin
			// Comment and blank lines do not scan as five fields
			while (!$feof(fd)) begin
				n = $fgets(line, fd);
				if (n > 0) begin
					n = $sscanf(line, "%d %d %h %h %d",
						f_m, f_rw, f_addr, f_data, f_resp);
					if (n == 5) begin
						xfers.push_back('{master: f_m, write: (f_rw != 0),
							addr: f_addr, data: f_data, resp: f_resp[0]});
					end
				end
			end
			$fclose(fd);
			if (xfers.size() == 0) begin
				abort_run("the transfer list holds no transfers");
			end
		end
	endtask

	task automatic check_idle_response();
		for (int m = 0; m < N_MASTERS; m++) begin
			assert (mst_resp[m].hready_resp == 1'b1) else begin
				report_mismatch("hready_resp", m, 32'(mst_resp[m].hready_resp), 32'd1);
			end
			assert (mst_resp[m].hresp == HRESP_OKAY) else begin
				report_mismatch("hresp", m, 32'(mst_resp[m].hresp), 32'(HRESP_OKAY));
			end
		end
	endtask

	// Runs one non-pipelined transfer and is entered right after a rising edge
	task automatic run_transfer(input int m, input xfer_t x);
		ahbl_req_t         req;
		logic              hresp_seen;
		logic [W_DATA-1:0] rdata_seen;
		int                cycles;
		req        = '0;
		req.haddr  = x.addr;
		req.hwrite = x.write;
		req.htrans = HTRANS_NONSEQ;
		req.hsize  = 3'b010;
		req.hprot  = 4'b0011;
		mst_req[m] <= req;
		@(posedge clk);
		req.htrans   = HTRANS_IDLE;
		mst_req[m]   <= req;
		mst_wdata[m] <= x.write ? x.data : '0;
		cycles = 0;
		@(negedge clk);
		// Stall cycles already carry the final response code
		while (!mst_resp[m].hready_resp && (cycles < 100)) begin
			assert (mst_resp[m].hresp == x.resp) else begin
				report_mismatch("hresp", m, 32'(mst_resp[m].hresp), 32'(x.resp));
			end
			@(negedge clk);
			cycles++;
		end
		if (!mst_resp[m].hready_resp) begin
			abort_run($sformatf("master %0d saw no hready_resp within 100 cycles at %h",
				m, x.addr));
		end else begin
			hresp_seen = mst_resp[m].hresp;
			rdata_seen = mst_resp[m].hrdata;
			assert (hresp_seen == x.resp) else begin
				report_mismatch("hresp", m, 32'(hresp_seen), 32'(x.resp));
			end
			// An ERROR response is one stalled cycle and one ready cycle
			if (x.resp == HRESP_ERROR) begin
				assert (cycles == 1) else begin
					abort_run($sformatf("master %0d ERROR response at %h stalled %0d cycles",
						m, x.addr, cycles));
				end
			end
			if (!x.write && (x.resp == HRESP_OKAY)) begin
				assert (rdata_seen == x.data) else begin
					report_mismatch("hrdata", m, rdata_seen, x.data);
				end
			end
			@(posedge clk);
		end
	endtask

	// Random idle gaps keep the two masters drifting against each other
	task automatic drive_master(input int m);
		int gap;
		bit first;
		first = 1'b1;
		for (int k = 0; k < xfers.size(); k++) begin
			if (xfers[k].master == m) begin
				if (!first) begin
					gap = $urandom % 4;
					repeat (gap) @(posedge clk);
				end
				first = 1'b0;
				run_transfer(m, xfers[k]);
			end
		end
	endtask

	initial begin
		void'($urandom(32'h6a3c5ea1));
		rst_n <= 1'b0;
		for (int m = 0; m < N_MASTERS; m++) begin
			mst_req[m]   <= '0;
			mst_wdata[m] <= '0;
		end
		load_transfers();
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_idle_response();
		@(posedge clk);
		fork
			drive_master(0);
			drive_master(1);
		join
		$display("Simulation passed");
		$finish;
	end

endmodule
